// File: sim/program_golden.hex
// kind 1 program word: address instruction; kind 2 expected retire: pc rd value
// kind 3 expected line request: line address; a single 0 ends the list
1 1000 00500093
1 1004 ffd00113
1 1008 002081b3
1 100c 40118233
1 1010 001272b3
1 1014 0022e333
1 1018 001343b3
1 101c 00112433
1 1020 001134b3
1 1024 05c007ef
1 1028 00100a13
1 102c 00200a93
1 1030 00e78833
1 1034 0000006f
1 1080 00109533
1 1084 001155b3
1 1088 40115633
1 108c 123456b7
1 1090 00168013
1 1094 00d00733
1 1098 ffe12893
1 109c fff6c913
1 10a0 40495993
1 10a4 0f09fa13
1 10a8 00fa6a93
1 10ac 100abb13
1 10b0 03fb1b93
1 10b4 f7dff06f
2 1000 01 0000000000000005
2 1004 02 fffffffffffffffd
2 1008 03 0000000000000002
2 100c 04 fffffffffffffffd
2 1010 05 0000000000000005
2 1014 06 fffffffffffffffd
2 1018 07 fffffffffffffff8
2 101c 08 0000000000000001
2 1020 09 0000000000000000
2 1024 0f 0000000000001028
2 1080 0a 00000000000000a0
2 1084 0b 07ffffffffffffff
2 1088 0c ffffffffffffffff
2 108c 0d 0000000012345000
2 1090 00 0000000000000000
2 1094 0e 0000000012345000
2 1098 11 0000000000000001
2 109c 12 ffffffffedcbafff
2 10a0 13 fffffffffedcbaff
2 10a4 14 00000000000000f0
2 10a8 15 00000000000000ff
2 10ac 16 0000000000000001
2 10b0 17 8000000000000000
2 10b4 00 0000000000000000
2 1030 10 0000000012346028
2 1034 00 0000000000000000
2 1034 00 0000000000000000
3 1000
3 1080
0

// File: vlog.f
source/core_pkg.sv
source/memory_controller.sv
source/icache.sv
source/decode.sv
source/execute.sv
source/top.sv
sim/top_properties.sv
sim/top_tb.sv

// File: sim/top_tb.sv
`timescale 1ns/1ps

module top_tb;
  import core_pkg::*;

  localparam int reset_cycles = 10;
  localparam int cycles_per_retire = 200;
  localparam int golden_depth = 512;
  localparam int mem_words = 64;
  localparam logic [word_width-1:0] mem_base = 64'h1000;
  localparam logic [word_width-1:0] entry_pc = 64'h1000;

  logic                  clk;
  logic                  reset;
  logic [word_width-1:0] entry;
  bus_req_t              bus_req;
  logic                  bus_reqack;
  bus_resp_t             bus_resp;
  logic                  bus_respack;
  retire_t               retire;
  logic                  retire_valid;

  logic [word_width-1:0] golden [golden_depth];
  logic [inst_width-1:0] mem [mem_words];
  retire_t               expected_retires [$];
  logic [word_width-1:0] expected_misses [$];
  int unsigned           retire_count;
  int unsigned           req_count;
  logic                  golden_loaded;

  top top_inst (
    .clk         (clk),
    .reset       (reset),
    .entry       (entry),
    .bus_req     (bus_req),
    .bus_reqack  (bus_reqack),
    .bus_resp    (bus_resp),
    .bus_respack (bus_respack),
    .retire      (retire),
    .retire_valid(retire_valid)
  );

  // every unused word gets an unsupported opcode
  function automatic logic [inst_width-1:0] fill_word(input logic [word_width-1:0] addr);
    logic [31:0] fold;
    fold = addr[63:32] ^ addr[31:0];
    return {fold[31:7] ^ fold[24:0], 7'h7f};
  endfunction

  function automatic logic [inst_width-1:0] read_word(input logic [word_width-1:0] addr);
    logic [word_width-1:0] index;
    index = (addr - mem_base) >> 2;
    if (index < mem_words) begin
      return mem[index];
    end else begin
      return fill_word(addr);
    end
  endfunction

  task automatic stop_with_failure();
    $display("STATUS: FAIL");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic check_retire(input retire_t got, input retire_t exp);
    if (got !== exp) begin
      $display("error: retire pc %h rd %h value %h, expected pc %h rd %h value %h",
               got.pc, got.rd, got.value, exp.pc, exp.rd, exp.value);
      stop_with_failure();
    end
  endtask

  task automatic check_bus_req(input bus_req_t got, input bus_req_t exp);
    if (got !== exp) begin
      $display("error: bus_req reqcyc %h req %h reqtag %h, expected reqcyc %h req %h reqtag %h",
               got.reqcyc, got.req, got.reqtag, exp.reqcyc, exp.req, exp.reqtag);
      stop_with_failure();
    end
  endtask

  task automatic check_respack(input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: bus_respack %h, expected %h", got, exp);
      stop_with_failure();
    end
  endtask

  // record kinds are 1 addr inst, 2 pc rd value, 3 line address and 0 ends the list
  task automatic load_golden();
    int unsigned           i;
    retire_t               rec;
    logic [word_width-1:0] offset;
    for (i = 0; i < mem_words; i++) begin
      mem[i] = fill_word(mem_base + word_width'(4 * i));
    end
    $readmemh("sim/program_golden.hex", golden);
    i = 0;
    while (golden[i] !== '0) begin
      case (golden[i])
        64'd1: begin
          offset = golden[i+1] - mem_base;
          mem[offset >> 2] = golden[i+2][inst_width-1:0];
          i += 3;
        end
        64'd2: begin
          rec.pc = golden[i+1];
          rec.rd = golden[i+2][4:0];
          rec.value = golden[i+3];
          expected_retires.push_back(rec);
          i += 4;
        end
        64'd3: begin
          expected_misses.push_back(golden[i+1]);
          i += 2;
        end
        default: begin
          $display("golden file is missing or holds an unknown record at entry %0d", i);
          stop_with_failure();
        end
      endcase
    end
  endtask

  // acknowledge after a random wait, then return the line as eight beats
  task automatic serve_request(input bus_req_t req);
    bus_req_t              exp;
    logic [word_width-1:0] addr;
    int unsigned           wait_cycles;
    int unsigned           gap;
    int unsigned           k;
    if (req_count >= expected_misses.size()) begin
      $display("unexpected bus request for line %h after all expected misses", req.req);
      stop_with_failure();
    end else begin
      exp.reqcyc = 1'b1;
      exp.req = expected_misses[req_count];
      exp.reqtag = bus_read_tag;
      check_bus_req(req, exp);
      req_count++;
      wait_cycles = $urandom_range(3, 0);
      @(posedge clk);
      #1;
      repeat (wait_cycles) begin
        @(posedge clk);
        #1;
      end
      bus_reqack = 1'b1;
      @(posedge clk);
      #1;
      bus_reqack = 1'b0;
      for (k = 0; k < beats_per_line; k++) begin
        gap = $urandom_range(2, 0);
        repeat (gap) begin
          @(negedge clk);
          check_respack(bus_respack, 1'b0);
          @(posedge clk);
          #1;
        end
        // two instructions per beat with the lower address in the low half
        addr = exp.req + word_width'(8 * k);
        bus_resp.respcyc = 1'b1;
        bus_resp.resp = {read_word(addr + word_width'(4)), read_word(addr)};
        bus_resp.resptag = bus_read_tag;
        @(negedge clk);
        check_respack(bus_respack, 1'b1);
        @(posedge clk);
        #1;
        bus_resp = '0;
      end
    end
  endtask

  task automatic finish_run();
    if (req_count != expected_misses.size()) begin
      $display("bus saw %0d line requests but %0d misses were expected",
               req_count, expected_misses.size());
      stop_with_failure();
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  initial begin
    reset = 1'b1;
    entry = entry_pc;
    retire_count = 0;
    req_count = 0;
    golden_loaded = 1'b0;
    load_golden();
    golden_loaded = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
  end

  initial begin : bus_model
    int unsigned seed_sink;
    bus_reqack = 1'b0;
    bus_resp = '0;
    seed_sink = $urandom(32'h977a_d1aa);
    forever begin
      @(negedge clk);
      if (!reset && bus_req.reqcyc === 1'b1) begin
        serve_request(bus_req);
      end
    end
  end

  // the first edge only loads the reset state
  initial begin
    @(posedge clk);
    repeat (reset_cycles) begin
      @(negedge clk);
      if (bus_req.reqcyc !== 1'b0 || retire_valid !== 1'b0) begin
        $display("bus request or retire seen while the core was held in reset");
        stop_with_failure();
      end
    end
  end

  initial begin
    wait (golden_loaded);
    forever begin
      @(negedge clk);
      if (!reset && retire_valid) begin
        check_retire(retire, expected_retires[retire_count]);
        retire_count++;
        if (retire_count == expected_retires.size()) begin
          finish_run();
        end
      end
    end
  end

  initial begin
    wait (golden_loaded);
    repeat (reset_cycles + cycles_per_retire * expected_retires.size()) @(posedge clk);
    $display("timeout with %0d of %0d expected retires seen",
             retire_count, expected_retires.size());
    stop_with_failure();
  end

endmodule

// File: sim/top_properties.sv
`timescale 1ns/1ps

module top_properties (
  input logic               clk,
  input logic               reset,
  input core_pkg::bus_req_t bus_req,
  input logic               bus_reqack,
  input logic               fill_valid
);

  // request fields hold until reqack and reqcyc drops right after it
  request_held: assert property (@(posedge clk) disable iff (reset)
    bus_req.reqcyc && !bus_reqack |=>
      bus_req.reqcyc && $stable(bus_req.req) && $stable(bus_req.reqtag))
    else $error("bus request dropped or changed before reqack");

  request_released: assert property (@(posedge clk) disable iff (reset)
    bus_req.reqcyc && bus_reqack |=> !bus_req.reqcyc)
    else $error("reqcyc still high in the cycle after reqack");

  fill_pulse: assert property (@(posedge clk) disable iff (reset)
    fill_valid |=> !fill_valid)
    else $error("fill_valid held longer than one cycle");

endmodule

bind memory_controller top_properties props_inst (
  .clk       (clk),
  .reset     (reset),
  .bus_req   (bus_req),
  .bus_reqack(bus_reqack),
  .fill_valid(fill_valid)
);

// File: source/top.sv
`timescale 1ns/1ps

module top (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [core_pkg::word_width-1:0] entry,
  output core_pkg::bus_req_t              bus_req,
  input  logic                            bus_reqack,
  input  core_pkg::bus_resp_t             bus_resp,
  output logic                            bus_respack,
  output core_pkg::retire_t               retire,
  output logic                            retire_valid
);
  import core_pkg::*;

  logic [word_width-1:0] pc;
  logic [word_width-1:0] fill_addr;
  logic [word_width-1:0] redirect_pc;
  logic [line_width-1:0] fill_line;
  logic                  hit;
  logic                  fill_req;
  logic                  fill_valid;
  logic                  redirect;
  logic                  retire_writes;
  inst_u                 inst;
  fetch_t                fetch;
  decoded_t              decoded;

  // a redirect wins over the sequential step and drops this cycle's fetch
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= entry;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (hit) begin
      pc <= pc + word_width'(4);
    end
  end

  assign fetch = '{valid: hit, pc: pc, inst: inst};

  memory_controller memory_controller_inst (
    .clk        (clk),
    .reset      (reset),
    .fill_req   (fill_req),
    .fill_addr  (fill_addr),
    .fill_valid (fill_valid),
    .fill_line  (fill_line),
    .bus_req    (bus_req),
    .bus_reqack (bus_reqack),
    .bus_resp   (bus_resp),
    .bus_respack(bus_respack)
  );

  icache icache_inst (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .hit       (hit),
    .inst      (inst),
    .fill_req  (fill_req),
    .fill_addr (fill_addr),
    .fill_valid(fill_valid),
    .fill_line (fill_line)
  );

  decode decode_inst (
    .clk      (clk),
    .reset    (reset),
    .fetch    (fetch),
    .flush    (redirect),
    .wb       (retire),
    .wb_valid (retire_valid),
    .wb_writes(retire_writes),
    .decoded  (decoded)
  );

  execute execute_inst (
    .clk          (clk),
    .reset        (reset),
    .decoded      (decoded),
    .retire       (retire),
    .retire_valid (retire_valid),
    .retire_writes(retire_writes),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc)
  );

endmodule

// File: source/execute.sv
`timescale 1ns/1ps

module execute (
  input  logic                            clk,
  input  logic                            reset,
  input  core_pkg::decoded_t              decoded,
  output core_pkg::retire_t               retire,
  output logic                            retire_valid,
  output logic                            retire_writes,
  output logic                            redirect,
  output logic [core_pkg::word_width-1:0] redirect_pc
);
  import core_pkg::*;

  logic [word_width-1:0] alu_result;
  logic [word_width-1:0] link;
  logic [word_width-1:0] result;
  logic [5:0]            shamt;
  logic                  writes;

  // rv64 shifts use six bits of the second operand
  assign shamt = decoded.operand_b[5:0];

  always_comb begin
    case (decoded.alu_op)
      alu_sub:  alu_result = decoded.operand_a - decoded.operand_b;
      alu_sll:  alu_result = decoded.operand_a << shamt;
      alu_slt: begin
        alu_result = {{(word_width-1){1'b0}},
                      $signed(decoded.operand_a) < $signed(decoded.operand_b)};
      end
      alu_sltu: begin
        alu_result = {{(word_width-1){1'b0}}, decoded.operand_a < decoded.operand_b};
      end
      alu_xor:  alu_result = decoded.operand_a ^ decoded.operand_b;
      alu_srl:  alu_result = decoded.operand_a >> shamt;
      alu_sra:  alu_result = $signed(decoded.operand_a) >>> shamt;
      alu_or:   alu_result = decoded.operand_a | decoded.operand_b;
      alu_and:  alu_result = decoded.operand_a & decoded.operand_b;
      default:  alu_result = decoded.operand_a + decoded.operand_b;
    endcase
  end

  // for jal the adder gives the target and rd gets pc + 4
  assign link = decoded.pc + word_width'(4);
  assign result = decoded.is_jal ? link : alu_result;
  assign writes = decoded.writes_rd && (decoded.rd != 5'd0);

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
      retire_writes <= 1'b0;
      redirect <= 1'b0;
    end else begin
      retire_valid <= decoded.valid;
      retire_writes <= decoded.valid && writes;
      redirect <= decoded.valid && decoded.is_jal;
    end
  end

  always_ff @(posedge clk) begin
    retire.pc <= decoded.pc;
    // non-writing records show up as rd 0 with a zero value
    retire.rd <= writes ? decoded.rd : 5'd0;
    retire.value <= writes ? result : '0;
    redirect_pc <= alu_result;
  end

endmodule

// File: source/decode.sv
`timescale 1ns/1ps

module decode (
  input  logic                 clk,
  input  logic                 reset,
  input  core_pkg::fetch_t     fetch,
  input  logic                 flush,
  input  core_pkg::retire_t    wb,
  input  logic                 wb_valid,
  input  logic                 wb_writes,
  output core_pkg::decoded_t   decoded
);
  import core_pkg::*;

  // fields held between fetch and execute, operands are read out later
  typedef struct packed {
    logic [word_width-1:0] pc;
    logic [4:0]            rd;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic                  a_is_pc;
    logic                  b_is_imm;
    logic [word_width-1:0] imm;
    alu_op_e               alu_op;
    logic                  is_jal;
    logic                  writes_rd;
  } stage_t;

  function automatic alu_op_e alu_for(input logic [2:0] funct3, input logic alt);
    alu_op_e op;
    case (funct3)
      3'd0: op = alt ? alu_sub : alu_add;
      3'd1: op = alu_sll;
      3'd2: op = alu_slt;
      3'd3: op = alu_sltu;
      3'd4: op = alu_xor;
      3'd5: op = alt ? alu_sra : alu_srl;
      3'd6: op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  inst_u                 inst;
  stage_t                stage_d;
  stage_t                stage_q;
  logic                  valid_q;
  logic [word_width-1:0] regs [1:31];
  logic [word_width-1:0] rs1_val;
  logic [word_width-1:0] rs2_val;
  logic                  wb_write;

  assign inst = fetch.inst;
  assign wb_write = wb_valid && wb_writes;

  always_comb begin
    stage_d = '0;
    stage_d.pc = fetch.pc;
    stage_d.rd = inst.r_fmt.rd;
    stage_d.rs1 = inst.r_fmt.rs1;
    stage_d.rs2 = inst.r_fmt.rs2;
    stage_d.b_is_imm = 1'b1;
    stage_d.imm = {{(word_width-12){inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    stage_d.alu_op = alu_add;
    case (inst.r_fmt.opcode)
      op_reg: begin
        stage_d.b_is_imm = 1'b0;
        stage_d.alu_op = alu_for(inst.r_fmt.funct3, inst.r_fmt.funct7[5]);
        stage_d.writes_rd = 1'b1;
      end
      op_imm: begin
        // bit 10 of the immediate picks srai, addi has no subtract form
        stage_d.alu_op = alu_for(inst.i_fmt.funct3,
                                 inst.i_fmt.funct3 == 3'd5 && inst.i_fmt.imm[10]);
        stage_d.writes_rd = 1'b1;
      end
      op_lui: begin
        // x0 plus the upper immediate
        stage_d.rs1 = 5'd0;
        stage_d.imm = {{(word_width-32){inst.j_fmt.imm[19]}}, inst.j_fmt.imm, 12'b0};
        stage_d.writes_rd = 1'b1;
      end
      op_jal: begin
        stage_d.a_is_pc = 1'b1;
        stage_d.imm = {{(word_width-21){inst.j_fmt.imm[19]}}, inst.j_fmt.imm[19],
                       inst.j_fmt.imm[7:0], inst.j_fmt.imm[8], inst.j_fmt.imm[18:9], 1'b0};
        stage_d.is_jal = 1'b1;
        stage_d.writes_rd = 1'b1;
      end
      default: begin
        stage_d.rd = 5'd0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= fetch.valid && !flush;
    end
  end

  always_ff @(posedge clk) begin
    stage_q <= stage_d;
    if (wb_write) begin
      regs[wb.rd] <= wb.value;
    end
  end

  // the instruction just ahead is in wb and not yet in the file
  always_comb begin
    if (stage_q.rs1 == 5'd0) begin
      rs1_val = '0;
    end else if (wb_write && wb.rd == stage_q.rs1) begin
      rs1_val = wb.value;
    end else begin
      rs1_val = regs[stage_q.rs1];
    end
    if (stage_q.rs2 == 5'd0) begin
      rs2_val = '0;
    end else if (wb_write && wb.rd == stage_q.rs2) begin
      rs2_val = wb.value;
    end else begin
      rs2_val = regs[stage_q.rs2];
    end
  end

  always_comb begin
    decoded.valid = valid_q && !flush;
    decoded.pc = stage_q.pc;
    decoded.rd = stage_q.rd;
    decoded.operand_a = stage_q.a_is_pc ? stage_q.pc : rs1_val;
    decoded.operand_b = stage_q.b_is_imm ? stage_q.imm : rs2_val;
    decoded.alu_op = stage_q.alu_op;
    decoded.is_jal = stage_q.is_jal;
    decoded.writes_rd = stage_q.writes_rd;
  end

endmodule

// File: source/icache.sv
`timescale 1ns/1ps

module icache (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [core_pkg::word_width-1:0] pc,
  output logic                            hit,
  output core_pkg::inst_u                 inst,
  output logic                            fill_req,
  output logic [core_pkg::word_width-1:0] fill_addr,
  input  logic                            fill_valid,
  input  logic [core_pkg::line_width-1:0] fill_line
);
  import core_pkg::*;

  logic [line_width-1:0]        lines [icache_lines];
  logic [icache_tag_bits-1:0]   tags [icache_lines];
  logic [icache_lines-1:0]      line_valid;
  logic [icache_index_bits-1:0] index;
  logic [icache_index_bits-1:0] fill_index;
  logic [icache_tag_bits-1:0]   pc_tag;
  logic [line_offset_bits-3:0]  word_sel;
  logic                         start_miss;

  assign index = pc[line_offset_bits +: icache_index_bits];
  assign pc_tag = pc[word_width-1 -: icache_tag_bits];
  assign word_sel = pc[line_offset_bits-1:2];
  assign fill_index = fill_addr[line_offset_bits +: icache_index_bits];

  // lookup is purely combinational so fetch sees hit in the same cycle
  assign hit = line_valid[index] && (tags[index] == pc_tag);
  assign inst = lines[index][word_sel*inst_width +: inst_width];

  assign start_miss = !fill_req && !hit;

  always_ff @(posedge clk) begin
    if (reset) begin
      line_valid <= '0;
      fill_req <= 1'b0;
    end else begin
      if (fill_valid) begin
        fill_req <= 1'b0;
        line_valid[fill_index] <= 1'b1;
      end else if (start_miss) begin
        fill_req <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    // line address is latched once, pc may move on a redirect
    if (start_miss) begin
      fill_addr <= pc & ~word_width'(line_bytes - 1);
    end
    if (fill_valid) begin
      lines[fill_index] <= fill_line;
      tags[fill_index] <= fill_addr[word_width-1 -: icache_tag_bits];
    end
  end

endmodule

// File: source/memory_controller.sv
`timescale 1ns/1ps

module memory_controller (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            fill_req,
  input  logic [core_pkg::word_width-1:0] fill_addr,
  output logic                            fill_valid,
  output logic [core_pkg::line_width-1:0] fill_line,
  output core_pkg::bus_req_t              bus_req,
  input  logic                            bus_reqack,
  input  core_pkg::bus_resp_t             bus_resp,
  output logic                            bus_respack
);
  import core_pkg::*;

  typedef enum logic [1:0] {
    mc_idle,
    mc_request,
    mc_collect
  } mc_state_e;

  mc_state_e                         state;
  logic [word_width-1:0]             line_addr;
  logic [line_width-1:0]             line_buf;
  logic [$clog2(beats_per_line)-1:0] beat_count;
  logic                              beat_ok;
  logic                              last_beat;

  assign beat_ok = (state == mc_collect) && bus_resp.respcyc &&
                   (bus_resp.resptag == bus_read_tag);
  assign last_beat = (beat_count == $bits(beat_count)'(beats_per_line - 1));

  // every beat on the bus is taken in the cycle it shows up
  assign bus_respack = bus_resp.respcyc;

  assign bus_req.reqcyc = (state == mc_request);
  assign bus_req.req = line_addr;
  assign bus_req.reqtag = bus_read_tag;

  assign fill_line = line_buf;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= mc_idle;
      beat_count <= '0;
      fill_valid <= 1'b0;
    end else begin
      fill_valid <= 1'b0;
      case (state)
        mc_idle: begin
          // fill_req is still up during the fill_valid cycle
          if (fill_req && !fill_valid) begin
            state <= mc_request;
            beat_count <= '0;
          end
        end
        mc_request: begin
          if (bus_reqack) begin
            state <= mc_collect;
          end
        end
        mc_collect: begin
          if (beat_ok) begin
            beat_count <= beat_count + 1'b1;
            if (last_beat) begin
              state <= mc_idle;
              fill_valid <= 1'b1;
            end
          end
        end
        default: begin
          state <= mc_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == mc_idle && fill_req) begin
      line_addr <= fill_addr;
    end
    // beats come lowest address first, so shift in from the top
    if (beat_ok) begin
      line_buf <= {bus_resp.resp, line_buf[line_width-1:word_width]};
    end
  end

endmodule

// File: source/core_pkg.sv
package core_pkg;

  localparam int word_width = 64;
  localparam int inst_width = 32;
  localparam int line_bytes = 64;
  localparam int line_width = line_bytes * 8;
  localparam int beats_per_line = line_width / word_width;
  localparam int icache_lines = 4;

  // address split for the instruction cache
  localparam int line_offset_bits = $clog2(line_bytes);
  localparam int icache_index_bits = $clog2(icache_lines);
  localparam int icache_tag_bits = word_width - line_offset_bits - icache_index_bits;

  // read request to memory: read bit, memory space, no sub-id
  localparam int bus_tag_width = 13;
  localparam logic [bus_tag_width-1:0] bus_read_tag = 13'h1100;

  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_jal = 7'b1101111;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // upper 20 bits, used by lui directly and by jal after unscrambling
  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    j_fmt_t j_fmt;
  } inst_u;

  typedef struct packed {
    logic                  valid;
    logic [word_width-1:0] pc;
    inst_u                 inst;
  } fetch_t;

  typedef struct packed {
    logic                  valid;
    logic [word_width-1:0] pc;
    logic [4:0]            rd;
    logic [word_width-1:0] operand_a;
    logic [word_width-1:0] operand_b;
    alu_op_e               alu_op;
    logic                  is_jal;
    logic                  writes_rd;
  } decoded_t;

  typedef struct packed {
    logic [word_width-1:0] pc;
    logic [4:0]            rd;
    logic [word_width-1:0] value;
  } retire_t;

  typedef struct packed {
    logic                     reqcyc;
    logic [word_width-1:0]    req;
    logic [bus_tag_width-1:0] reqtag;
  } bus_req_t;

  typedef struct packed {
    logic                     respcyc;
    logic [word_width-1:0]    resp;
    logic [bus_tag_width-1:0] resptag;
  } bus_resp_t;

endpackage
